//--- verilog.f
+incdir+.
axis_pkg.sv
tlp_pkg.sv
tlp_beat_if.sv
axis_rx_stage.sv
tlp_hdr_decode.sv
tlp_payload_route.sv
tlp_rcv_top.sv
tb_tlp_rcv_top.sv

//--- Bender.yml
package:
  name: tlp_rcv

sources:
  - files:
      - axis_pkg.sv
      - tlp_pkg.sv
      - tlp_beat_if.sv
      - axis_rx_stage.sv
      - tlp_hdr_decode.sv
      - tlp_payload_route.sv
      - tlp_rcv_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tlp_rcv_top.sv

//--- tb_tlp_model.svh
`ifndef TB_TLP_MODEL_SVH
`define TB_TLP_MODEL_SVH

//////////////////////////////////////////////////
// packet builders
//////////////////////////////////////////////////
// request header for MRd and MWr, fmt bit 5 selects the 4dw form
function automatic logic [127:0] build_req_hdr(input tlp_pkg::tlp_fmt_type_t ft,
                                               input logic [9:0] len, input logic [2:0] tc,
                                               input logic [2:0] attr, input logic [15:0] id,
                                               input logic [7:0] tag, input logic [7:0] be,
                                               input logic [63:0] addr);
    logic [127:0] h;
    h = '0;
    h[tlp_pkg::FMT_TYPE_LO +: 8]          = ft;
    h[tlp_pkg::LEN_LO +: tlp_pkg::LEN_W]  = len;
    h[tlp_pkg::TC_LO +: tlp_pkg::TC_W]    = tc;
    h[tlp_pkg::ATTR_HI_BIT]               = attr[2];
    h[tlp_pkg::ATTR_LO +: 2]              = attr[1:0];
    h[tlp_pkg::REQ_ID_LO +: tlp_pkg::ID_W] = id;
    h[tlp_pkg::TAG_LO +: tlp_pkg::TAG_W]  = tag;
    h[tlp_pkg::BE_LO +: tlp_pkg::BE_W]    = be;
    if (ft[5])
    begin
        h[tlp_pkg::ADDR_DW2_LO +: 32] = addr[63:32];
        h[tlp_pkg::ADDR_DW3_LO +: 32] = addr[31:0];
    end
    else
    begin
        h[tlp_pkg::ADDR_DW2_LO +: 32] = addr[31:0];
    end
    return h;
endfunction

function automatic logic [127:0] build_cpl_hdr(input logic [9:0] len, input logic [11:0] bcnt,
                                               input logic [6:0] laddr, input logic [7:0] tag);
    logic [127:0] h;
    h = '0;
    h[tlp_pkg::FMT_TYPE_LO +: 8]               = tlp_pkg::CPLD;
    h[tlp_pkg::LEN_LO +: tlp_pkg::LEN_W]       = len;
    h[tlp_pkg::BCNT_LO +: tlp_pkg::BCNT_W]     = bcnt;
    h[tlp_pkg::LADDR_LO +: tlp_pkg::LADDR_W]   = laddr;
    h[tlp_pkg::CPL_TAG_LO +: tlp_pkg::TAG_W]   = tag;
    return h;
endfunction

//////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////
// byte 0 of each dword moves to byte 3
function automatic logic [127:0] swap_dw(input logic [127:0] d);
    logic [127:0] r;
    for (int w = 0; w < 4; w++)
        for (int b = 0; b < 4; b++)
            r[32*w + 8*b +: 8] = d[32*w + 8*(3-b) +: 8];
    return r;
endfunction

// dword aligned, upper half zero for the 3dw form
function automatic logic [63:0] expect_addr(input logic is64, input logic [63:0] a);
    return is64 ? {a[63:2], 2'b00} : {32'h0, a[31:2], 2'b00};
endfunction

task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act)
    begin
        $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
        abort_run("value check failed");
    end
endtask

`endif

//--- tb_tlp_rcv_top.sv
`default_nettype none

module tb_tlp_rcv_top;

    localparam int CLK_HALF = 5;

    // expected payload beat, stamped with its drive time
    typedef struct packed {
        logic [63:0]  stamp;
        logic [3:0]   keep;
        logic [127:0] data;
    } exp_beat_t;

    logic clk = 1'b0;
    logic rst_n;
    logic i_axis_tvld;
    logic [axis_pkg::DATA_W-1:0] i_axis_tdata;
    logic [axis_pkg::KEEP_W-1:0] i_axis_tkeep;
    logic i_axis_tlast;
    logic [axis_pkg::USER_W-1:0] i_axis_tuser;
    logic i_cpld_req_rdy;
    logic i_cpld_tx_rdy;
    logic i_tag_full;
    logic o_axis_trdy;
    logic [axis_pkg::HALT_W-1:0] o_pkt_halt;
    logic o_cpld_req_vld;
    logic o_cpld_rcv;
    logic [tlp_pkg::LEN_W-1:0] o_mrd_length;
    logic [tlp_pkg::TC_W-1:0] o_mrd_tc;
    logic [tlp_pkg::ATTR_W-1:0] o_mrd_attr;
    logic [tlp_pkg::ID_W-1:0] o_mrd_id;
    logic [tlp_pkg::TAG_W-1:0] o_mrd_tag;
    logic [tlp_pkg::ADDR_W-1:0] o_mrd_addr;
    logic [tlp_pkg::LEN_W-1:0] o_mwr_length;
    logic [tlp_pkg::BE_W-1:0] o_mwr_dwbe;
    logic [tlp_pkg::ADDR_W-1:0] o_mwr_addr;
    logic o_mwr_wr_start;
    logic [axis_pkg::DATA_W-1:0] o_mwr_data;
    logic [axis_pkg::KEEP_W-1:0] o_mwr_dw_vld;
    logic [tlp_pkg::LEN_W-1:0] o_cpld_length;
    logic [tlp_pkg::BCNT_W-1:0] o_cpld_byte_cnt;
    logic [tlp_pkg::LADDR_W-1:0] o_cpld_low_addr;
    logic [tlp_pkg::TAG_W-1:0] o_cpld_tag;
    logic o_multicpld_flag;
    logic o_cpld_wr_start;
    logic [axis_pkg::DATA_W-1:0] o_cpld_data;
    logic [axis_pkg::KEEP_W-1:0] o_cpld_dw_vld;

    integer seed;
    int rcv_count = 0;
    int rcv_before;
    exp_beat_t mwr_q[$];
    exp_beat_t cpld_q[$];
    logic [63:0] addr;
    logic [63:0] addr_b;

    tlp_rcv_top tlp_rcv_top_inst
    (
        .clk (clk), .rst_n (rst_n),
        .i_axis_tvld (i_axis_tvld), .i_axis_tdata (i_axis_tdata),
        .i_axis_tkeep (i_axis_tkeep), .i_axis_tlast (i_axis_tlast),
        .i_axis_tuser (i_axis_tuser), .i_cpld_req_rdy (i_cpld_req_rdy),
        .i_cpld_tx_rdy (i_cpld_tx_rdy), .i_tag_full (i_tag_full),
        .o_axis_trdy (o_axis_trdy), .o_pkt_halt (o_pkt_halt),
        .o_cpld_req_vld (o_cpld_req_vld), .o_cpld_rcv (o_cpld_rcv),
        .o_mrd_length (o_mrd_length), .o_mrd_tc (o_mrd_tc), .o_mrd_attr (o_mrd_attr),
        .o_mrd_id (o_mrd_id), .o_mrd_tag (o_mrd_tag), .o_mrd_addr (o_mrd_addr),
        .o_mwr_length (o_mwr_length), .o_mwr_dwbe (o_mwr_dwbe), .o_mwr_addr (o_mwr_addr),
        .o_mwr_wr_start (o_mwr_wr_start), .o_mwr_data (o_mwr_data),
        .o_mwr_dw_vld (o_mwr_dw_vld), .o_cpld_length (o_cpld_length),
        .o_cpld_byte_cnt (o_cpld_byte_cnt), .o_cpld_low_addr (o_cpld_low_addr),
        .o_cpld_tag (o_cpld_tag), .o_multicpld_flag (o_multicpld_flag),
        .o_cpld_wr_start (o_cpld_wr_start), .o_cpld_data (o_cpld_data),
        .o_cpld_dw_vld (o_cpld_dw_vld)
    );

    always #CLK_HALF clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    `include "tb_tlp_model.svh"

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////
    function automatic logic [127:0] rand_beat();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic send_beat(input logic [127:0] d, input logic [3:0] k, input logic last,
                             input logic [7:0] user, input tlp_pkg::tlp_class_t pay);
        exp_beat_t e;
        @(posedge clk);
        i_axis_tvld  <= 1'b1;
        i_axis_tdata <= d;
        i_axis_tkeep <= k;
        i_axis_tlast <= last;
        i_axis_tuser <= user;
        e.stamp = $time;
        e.keep  = k;
        e.data  = swap_dw(d);
        if (pay == tlp_pkg::CLS_MWR)
            mwr_q.push_back(e);
        else if (pay == tlp_pkg::CLS_CPLD)
            cpld_q.push_back(e);
    endtask

    task automatic send_idle();
        @(posedge clk);
        i_axis_tvld  <= 1'b0;
        i_axis_tlast <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (mwr_q.size() != 0 || cpld_q.size() != 0)
        begin
            @(negedge clk);
            n++;
            if (n > 50)
                abort_run("Timed out waiting for payload write strobes");
        end
    endtask

    task automatic wait_req(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (o_cpld_req_vld !== level)
        begin
            @(negedge clk);
            n++;
            if (n > 50)
                abort_run("Timed out waiting for the completion request level");
        end
    endtask

    // request drops one cycle after tx takes it
    task automatic take_req(input string name);
        @(posedge clk);
        i_cpld_req_rdy <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_val(name, 0, o_cpld_req_vld);
        @(posedge clk);
        i_cpld_req_rdy <= 1'b0;
    endtask

    task automatic run_cpld(input logic last_cpl, input string name);
        rcv_before = rcv_count;
        send_beat(build_cpl_hdr(10'd8, 12'h020, 7'h44, 8'h9A), 4'b0111, 1'b0,
                  {4'b0, last_cpl, 3'b0}, tlp_pkg::CLS_NONE);
        send_beat(rand_beat(), 4'hF, 1'b0, 8'h00, tlp_pkg::CLS_CPLD);
        send_beat(rand_beat(), 4'h7, 1'b1, 8'h00, tlp_pkg::CLS_CPLD);
        send_idle();
        wait_drain();
        check_val({name, " length"}, 10'd8, o_cpld_length);
        check_val({name, " byte count"}, 12'h020, o_cpld_byte_cnt);
        check_val({name, " lower addr"}, 7'h44, o_cpld_low_addr);
        check_val({name, " tag"}, 8'h9A, o_cpld_tag);
        check_val({name, " multi flag"}, !last_cpl, o_multicpld_flag);
        check_val({name, " tag release"}, last_cpl, rcv_count - rcv_before);
    endtask

    task automatic set_halt(input logic tag_full, input logic tx_rdy);
        logic [axis_pkg::HALT_W-1:0] exp;
        exp = '0;
        exp[axis_pkg::HALT_CPL] = tag_full;
        exp[axis_pkg::HALT_NP]  = ~tx_rdy;
        @(posedge clk);
        i_tag_full    <= tag_full;
        i_cpld_tx_rdy <= tx_rdy;
        @(posedge clk);
        @(negedge clk);
        check_val("halt vector", exp, o_pkt_halt);
    endtask

    //////////////////////////////////////////////////
    // compare process
    //////////////////////////////////////////////////
    always @(negedge clk)
    begin : compare_strobes
        exp_beat_t e;
        if (rst_n)
        begin
            if (o_mwr_wr_start)
            begin
                if (mwr_q.size() == 0)
                    abort_run("Unexpected memory write data strobe");
                e = mwr_q.pop_front();
                check_val("mwr data", e.data, o_mwr_data);
                check_val("mwr dword mask", e.keep, o_mwr_dw_vld);
                check_val("mwr latency", 3, (($time - e.stamp) - CLK_HALF) / (2 * CLK_HALF));
            end
            if (o_cpld_wr_start)
            begin
                if (cpld_q.size() == 0)
                    abort_run("Unexpected completion data strobe");
                e = cpld_q.pop_front();
                check_val("cpld data", e.data, o_cpld_data);
                check_val("cpld dword mask", e.keep, o_cpld_dw_vld);
                check_val("cpld latency", 3, (($time - e.stamp) - CLK_HALF) / (2 * CLK_HALF));
            end
            if (o_cpld_rcv)
                rcv_count++;
        end
    end

    initial
    begin
        seed           = 32'hbab1;
        rst_n          = 1'b0;
        i_axis_tvld    = 1'b0;
        i_axis_tdata   = '0;
        i_axis_tkeep   = '0;
        i_axis_tlast   = 1'b0;
        i_axis_tuser   = '0;
        i_cpld_req_rdy = 1'b0;
        i_cpld_tx_rdy  = 1'b1;
        i_tag_full     = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("halt after reset", 0, o_pkt_halt);
        check_val("request after reset", 0, o_cpld_req_vld);
        check_val("trdy", 1, o_axis_trdy);

        // mwr with a 3dw header
        addr = {$random(seed), $random(seed)};
        send_beat(build_req_hdr(tlp_pkg::MWR_32, 10'd8, 3'd0, 3'd0, 16'h0100, 8'h05, 8'hFF, addr),
                  4'b0111, 1'b0, 8'h00, tlp_pkg::CLS_NONE);
        send_beat(rand_beat(), 4'hF, 1'b0, 8'h00, tlp_pkg::CLS_MWR);
        send_beat(rand_beat(), 4'h3, 1'b1, 8'h00, tlp_pkg::CLS_MWR);
        send_idle();
        wait_drain();
        check_val("mwr32 length", 10'd8, o_mwr_length);
        check_val("mwr32 byte enables", 8'hFF, o_mwr_dwbe);
        check_val("mwr32 addr", expect_addr(1'b0, addr), o_mwr_addr);

        // mwr with a 4dw header
        addr = {$random(seed), $random(seed)};
        send_beat(build_req_hdr(tlp_pkg::MWR_64, 10'd4, 3'd0, 3'd0, 16'h0100, 8'h06, 8'h0F, addr),
                  4'hF, 1'b0, 8'h00, tlp_pkg::CLS_NONE);
        send_beat(rand_beat(), 4'hF, 1'b1, 8'h00, tlp_pkg::CLS_MWR);
        send_idle();
        wait_drain();
        check_val("mwr64 addr", expect_addr(1'b1, addr), o_mwr_addr);

        // mrd whose request is held until tx is ready
        addr = {$random(seed), $random(seed)};
        send_beat(build_req_hdr(tlp_pkg::MRD_64, 10'd16, 3'd5, 3'd6, 16'hBEEF, 8'h3C, 8'h0F, addr),
                  4'hF, 1'b1, 8'h00, tlp_pkg::CLS_NONE);
        send_idle();
        wait_req(1'b1);
        check_val("mrd length", 10'd16, o_mrd_length);
        check_val("mrd tc", 3'd5, o_mrd_tc);
        check_val("mrd attr", 3'd6, o_mrd_attr);
        check_val("mrd id", 16'hBEEF, o_mrd_id);
        check_val("mrd tag", 8'h3C, o_mrd_tag);
        check_val("mrd addr", expect_addr(1'b1, addr), o_mrd_addr);
        repeat (6)
        begin
            @(negedge clk);
            check_val("mrd request held", 1, o_cpld_req_vld);
        end
        take_req("mrd request cleared");

        run_cpld(1'b1, "cpld last");
        run_cpld(1'b0, "cpld multi");

        // back to back mwr, cpld, mrd
        addr   = {$random(seed), $random(seed)};
        addr_b = {$random(seed), $random(seed)};
        rcv_before = rcv_count;
        send_beat(build_req_hdr(tlp_pkg::MWR_32, 10'd4, 3'd0, 3'd0, 16'h0200, 8'h11, 8'h3F, addr),
                  4'b0111, 1'b0, 8'h00, tlp_pkg::CLS_NONE);
        send_beat(rand_beat(), 4'hF, 1'b1, 8'h00, tlp_pkg::CLS_MWR);
        send_beat(build_cpl_hdr(10'd4, 12'h010, 7'h08, 8'h77), 4'b0111, 1'b0, 8'h08,
                  tlp_pkg::CLS_NONE);
        send_beat(rand_beat(), 4'hF, 1'b1, 8'h00, tlp_pkg::CLS_CPLD);
        send_beat(build_req_hdr(tlp_pkg::MRD_32, 10'd2, 3'd1, 3'd2, 16'h0300, 8'h42, 8'h0F, addr_b),
                  4'b0111, 1'b1, 8'h00, tlp_pkg::CLS_NONE);
        send_idle();
        wait_drain();
        wait_req(1'b1);
        check_val("b2b mwr addr", expect_addr(1'b0, addr), o_mwr_addr);
        check_val("b2b mwr byte enables", 8'h3F, o_mwr_dwbe);
        check_val("b2b cpld tag", 8'h77, o_cpld_tag);
        check_val("b2b cpld byte count", 12'h010, o_cpld_byte_cnt);
        check_val("b2b tag release", 1, rcv_count - rcv_before);
        check_val("b2b mrd tag", 8'h42, o_mrd_tag);
        check_val("b2b mrd addr", expect_addr(1'b0, addr_b), o_mrd_addr);
        check_val("b2b mrd length", 10'd2, o_mrd_length);
        take_req("b2b request cleared");

        // halt mirrors
        set_halt(1'b1, 1'b1);
        set_halt(1'b1, 1'b0);
        set_halt(1'b0, 1'b0);
        set_halt(1'b0, 1'b1);

        repeat (5) @(negedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tlp_rcv_top.sv
`default_nettype none

module tlp_rcv_top
(
    input  logic                           clk,
    input  logic                           rst_n,
    // stream from the core
    input  logic                           i_axis_tvld,
    input  logic [axis_pkg::DATA_W-1:0]    i_axis_tdata,
    input  logic [axis_pkg::KEEP_W-1:0]    i_axis_tkeep,
    input  logic                           i_axis_tlast,
    input  logic [axis_pkg::USER_W-1:0]    i_axis_tuser,
    input  logic                           i_cpld_req_rdy,
    input  logic                           i_cpld_tx_rdy,
    input  logic                           i_tag_full,
    output logic                           o_axis_trdy,
    output logic [axis_pkg::HALT_W-1:0]    o_pkt_halt,
    output logic                           o_cpld_req_vld,
    output logic                           o_cpld_rcv,
    // memory read
    output logic [tlp_pkg::LEN_W-1:0]      o_mrd_length,
    output logic [tlp_pkg::TC_W-1:0]       o_mrd_tc,
    output logic [tlp_pkg::ATTR_W-1:0]     o_mrd_attr,
    output logic [tlp_pkg::ID_W-1:0]       o_mrd_id,
    output logic [tlp_pkg::TAG_W-1:0]      o_mrd_tag,
    output logic [tlp_pkg::ADDR_W-1:0]     o_mrd_addr,
    // memory write
    output logic [tlp_pkg::LEN_W-1:0]      o_mwr_length,
    output logic [tlp_pkg::BE_W-1:0]       o_mwr_dwbe,
    output logic [tlp_pkg::ADDR_W-1:0]     o_mwr_addr,
    output logic                           o_mwr_wr_start,
    output logic [axis_pkg::DATA_W-1:0]    o_mwr_data,
    output logic [axis_pkg::KEEP_W-1:0]    o_mwr_dw_vld,
    // completion with data
    output logic [tlp_pkg::LEN_W-1:0]      o_cpld_length,
    output logic [tlp_pkg::BCNT_W-1:0]     o_cpld_byte_cnt,
    output logic [tlp_pkg::LADDR_W-1:0]    o_cpld_low_addr,
    output logic [tlp_pkg::TAG_W-1:0]      o_cpld_tag,
    output logic                           o_multicpld_flag,
    output logic                           o_cpld_wr_start,
    output logic [axis_pkg::DATA_W-1:0]    o_cpld_data,
    output logic [axis_pkg::KEEP_W-1:0]    o_cpld_dw_vld
);

    tlp_beat_if beat_if ();

    tlp_pkg::tlp_class_t           pay_class;
    logic                          pay_active;
    logic [tlp_pkg::LEN_W-1:0]     tlp_length;

    // no back-pressure on the stream, halt vector only
    assign o_axis_trdy = 1'b1;

    //////////////////////////////////////////////////
    // input register stage
    //////////////////////////////////////////////////
    axis_rx_stage axis_rx_stage_inst
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_tvld        (i_axis_tvld),
        .i_tdata       (i_axis_tdata),
        .i_tkeep       (i_axis_tkeep),
        .i_tlast       (i_axis_tlast),
        .i_tuser       (i_axis_tuser),
        .i_tag_full    (i_tag_full),
        .i_cpld_tx_rdy (i_cpld_tx_rdy),
        .beat          (beat_if.src),
        .o_pkt_halt    (o_pkt_halt)
    );

    //////////////////////////////////////////////////
    // header decode
    //////////////////////////////////////////////////
    tlp_hdr_decode tlp_hdr_decode_inst
    (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_cpld_req_rdy   (i_cpld_req_rdy),
        .beat             (beat_if.snk),
        .o_pay_class      (pay_class),
        .o_pay_active     (pay_active),
        .o_tlp_length     (tlp_length),
        .o_mrd_tc         (o_mrd_tc),
        .o_mrd_attr       (o_mrd_attr),
        .o_mrd_id         (o_mrd_id),
        .o_mrd_tag        (o_mrd_tag),
        .o_mrd_addr       (o_mrd_addr),
        .o_mwr_dwbe       (o_mwr_dwbe),
        .o_mwr_addr       (o_mwr_addr),
        .o_cpld_byte_cnt  (o_cpld_byte_cnt),
        .o_cpld_low_addr  (o_cpld_low_addr),
        .o_cpld_tag       (o_cpld_tag),
        .o_multicpld_flag (o_multicpld_flag),
        .o_cpld_req_vld   (o_cpld_req_vld),
        .o_cpld_rcv       (o_cpld_rcv)
    );

    // one length register serves all three classes
    assign o_mrd_length  = tlp_length;
    assign o_mwr_length  = tlp_length;
    assign o_cpld_length = tlp_length;

    //////////////////////////////////////////////////
    // payload steering
    //////////////////////////////////////////////////
    tlp_payload_route tlp_payload_route_inst
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_pay_class     (pay_class),
        .i_pay_active    (pay_active),
        .beat            (beat_if.snk),
        .o_mwr_wr_start  (o_mwr_wr_start),
        .o_mwr_data      (o_mwr_data),
        .o_mwr_dw_vld    (o_mwr_dw_vld),
        .o_cpld_wr_start (o_cpld_wr_start),
        .o_cpld_data     (o_cpld_data),
        .o_cpld_dw_vld   (o_cpld_dw_vld)
    );

endmodule

`default_nettype wire

//--- tlp_payload_route.sv
`default_nettype none

module tlp_payload_route
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  tlp_pkg::tlp_class_t         i_pay_class,
    input  logic                        i_pay_active,
    tlp_beat_if.snk                     beat,
    output logic                        o_mwr_wr_start,
    output logic [axis_pkg::DATA_W-1:0] o_mwr_data,
    output logic [axis_pkg::KEEP_W-1:0] o_mwr_dw_vld,
    output logic                        o_cpld_wr_start,
    output logic [axis_pkg::DATA_W-1:0] o_cpld_data,
    output logic [axis_pkg::KEEP_W-1:0] o_cpld_dw_vld
);

    localparam int DW_W = axis_pkg::DATA_W / axis_pkg::KEEP_W;

    logic [axis_pkg::DATA_W-1:0] swapped;
    logic                        mwr_hit;
    logic                        cpld_hit;

    // little to big endian inside each dword
    always_comb
    begin
        for (int i = 0; i < axis_pkg::KEEP_W; i++)
            swapped[DW_W*i +: DW_W] = {<<8{beat.data[DW_W*i +: DW_W]}};
    end

    assign mwr_hit  = beat.valid && i_pay_active && (i_pay_class == tlp_pkg::CLS_MWR);
    assign cpld_hit = beat.valid && i_pay_active && (i_pay_class == tlp_pkg::CLS_CPLD);

    //////////////////////////////////////////////////
    // start strobes
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_mwr_wr_start  <= 1'b0;
            o_cpld_wr_start <= 1'b0;
        end
        else
        begin
            o_mwr_wr_start  <= mwr_hit;
            o_cpld_wr_start <= cpld_hit;
        end
    end

    // data and mask, valid together with the strobe
    always_ff @(posedge clk)
    begin
        if (mwr_hit)
        begin
            o_mwr_data   <= swapped;
            o_mwr_dw_vld <= beat.keep;
        end
        if (cpld_hit)
        begin
            o_cpld_data   <= swapped;
            o_cpld_dw_vld <= beat.keep;
        end
    end

endmodule

`default_nettype wire

//--- tlp_hdr_decode.sv
`default_nettype none

module tlp_hdr_decode
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           i_cpld_req_rdy,
    tlp_beat_if.snk                        beat,
    // to the payload router
    output tlp_pkg::tlp_class_t            o_pay_class,
    output logic                           o_pay_active,
    // captured header fields
    output logic [tlp_pkg::LEN_W-1:0]      o_tlp_length,
    output logic [tlp_pkg::TC_W-1:0]       o_mrd_tc,
    output logic [tlp_pkg::ATTR_W-1:0]     o_mrd_attr,
    output logic [tlp_pkg::ID_W-1:0]       o_mrd_id,
    output logic [tlp_pkg::TAG_W-1:0]      o_mrd_tag,
    output logic [tlp_pkg::ADDR_W-1:0]     o_mrd_addr,
    output logic [tlp_pkg::BE_W-1:0]       o_mwr_dwbe,
    output logic [tlp_pkg::ADDR_W-1:0]     o_mwr_addr,
    output logic [tlp_pkg::BCNT_W-1:0]     o_cpld_byte_cnt,
    output logic [tlp_pkg::LADDR_W-1:0]    o_cpld_low_addr,
    output logic [tlp_pkg::TAG_W-1:0]      o_cpld_tag,
    output logic                           o_multicpld_flag,
    // control
    output logic                           o_cpld_req_vld,
    output logic                           o_cpld_rcv
);

    typedef enum logic [1:0] {
        S_IDLE    = 2'd0,
        S_HEADER  = 2'd1,
        S_PAYLOAD = 2'd2
    } state_t;

    state_t                        state_q;
    state_t                        state_d;
    tlp_pkg::tlp_fmt_type_t        fmt_type;
    tlp_pkg::tlp_class_t           hdr_class;
    tlp_pkg::tlp_class_t           pay_class_q;
    logic                          hdr_vld;
    logic                          hdr_64;
    logic [tlp_pkg::ADDR_W-1:0]    hdr_addr;

    //////////////////////////////////////////////////
    // packet FSM
    //////////////////////////////////////////////////
    // a last beat always returns to idle, so the next beat is a header
    always_comb
    begin
        state_d = state_q;
        if (beat.valid)
        begin
            if (beat.last)
                state_d = S_IDLE;
            else if (state_q == S_IDLE)
                state_d = S_HEADER;
            else
                state_d = S_PAYLOAD;
        end
    end

    assign hdr_vld = beat.valid && (state_q == S_IDLE);

    //////////////////////////////////////////////////
    // header classification
    //////////////////////////////////////////////////
    assign fmt_type = tlp_pkg::tlp_fmt_type_t'(beat.data[tlp_pkg::FMT_TYPE_LO +: 8]);

    always_comb
    begin
        hdr_class = tlp_pkg::CLS_NONE;
        hdr_64    = 1'b0;
        case (fmt_type)
            tlp_pkg::MRD_32, tlp_pkg::MRDLK_32:
                hdr_class = tlp_pkg::CLS_MRD;
            tlp_pkg::MRD_64, tlp_pkg::MRDLK_64:
            begin
                hdr_class = tlp_pkg::CLS_MRD;
                hdr_64    = 1'b1;
            end
            tlp_pkg::MWR_32:
                hdr_class = tlp_pkg::CLS_MWR;
            tlp_pkg::MWR_64:
            begin
                hdr_class = tlp_pkg::CLS_MWR;
                hdr_64    = 1'b1;
            end
            tlp_pkg::CPLD, tlp_pkg::CPLDLK:
                hdr_class = tlp_pkg::CLS_CPLD;
            default:
                hdr_class = tlp_pkg::CLS_NONE;
        endcase
    end

    // 3dw header keeps addr[31:2] in dw2, 4dw splits it over dw2 and dw3
    assign hdr_addr = hdr_64 ?
        {beat.data[tlp_pkg::ADDR_DW2_LO +: 32], beat.data[tlp_pkg::ADDR_DW3_LO + 2 +: 30], 2'b00} :
        {32'b0, beat.data[tlp_pkg::ADDR_DW2_LO + 2 +: 30], 2'b00};

    //////////////////////////////////////////////////
    // field capture
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (hdr_vld)
        begin
            o_tlp_length <= beat.data[tlp_pkg::LEN_LO +: tlp_pkg::LEN_W];
            if (hdr_class == tlp_pkg::CLS_MRD)
            begin
                o_mrd_tc   <= beat.data[tlp_pkg::TC_LO +: tlp_pkg::TC_W];
                o_mrd_attr <= {beat.data[tlp_pkg::ATTR_HI_BIT], beat.data[tlp_pkg::ATTR_LO +: 2]};
                o_mrd_id   <= beat.data[tlp_pkg::REQ_ID_LO +: tlp_pkg::ID_W];
                o_mrd_tag  <= beat.data[tlp_pkg::TAG_LO +: tlp_pkg::TAG_W];
                o_mrd_addr <= hdr_addr;
            end
            else if (hdr_class == tlp_pkg::CLS_MWR)
            begin
                o_mwr_dwbe <= beat.data[tlp_pkg::BE_LO +: tlp_pkg::BE_W];
                o_mwr_addr <= hdr_addr;
            end
            else if (hdr_class == tlp_pkg::CLS_CPLD)
            begin
                o_cpld_byte_cnt  <= beat.data[tlp_pkg::BCNT_LO +: tlp_pkg::BCNT_W];
                o_cpld_low_addr  <= beat.data[tlp_pkg::LADDR_LO +: tlp_pkg::LADDR_W];
                o_cpld_tag       <= beat.data[tlp_pkg::CPL_TAG_LO +: tlp_pkg::TAG_W];
                o_multicpld_flag <= ~beat.user[axis_pkg::USER_LAST_CPL];
            end
        end
    end

    //////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q        <= S_IDLE;
            pay_class_q    <= tlp_pkg::CLS_NONE;
            o_cpld_req_vld <= 1'b0;
            o_cpld_rcv     <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (hdr_vld)
                pay_class_q <= hdr_class;
            // completion request holds until tx takes it
            if (hdr_vld && (hdr_class == tlp_pkg::CLS_MRD))
                o_cpld_req_vld <= 1'b1;
            else if (i_cpld_req_rdy)
                o_cpld_req_vld <= 1'b0;
            // tag release only on the final completion
            o_cpld_rcv <= hdr_vld && (hdr_class == tlp_pkg::CLS_CPLD) &&
                          beat.user[axis_pkg::USER_LAST_CPL];
        end
    end

    assign o_pay_class  = pay_class_q;
    assign o_pay_active = (state_q != S_IDLE) &&
                          ((pay_class_q == tlp_pkg::CLS_MWR) ||
                           (pay_class_q == tlp_pkg::CLS_CPLD));

endmodule

`default_nettype wire

//--- axis_rx_stage.sv
`default_nettype none

module axis_rx_stage
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_tvld,
    input  logic [axis_pkg::DATA_W-1:0] i_tdata,
    input  logic [axis_pkg::KEEP_W-1:0] i_tkeep,
    input  logic                        i_tlast,
    input  logic [axis_pkg::USER_W-1:0] i_tuser,
    input  logic                        i_tag_full,
    input  logic                        i_cpld_tx_rdy,
    tlp_beat_if.src                     beat,
    output logic [axis_pkg::HALT_W-1:0] o_pkt_halt
);

    logic                        vld_s1;
    logic [axis_pkg::DATA_W-1:0] data_s1;
    logic [axis_pkg::KEEP_W-1:0] keep_s1;
    logic                        last_s1;
    logic [axis_pkg::USER_W-1:0] user_s1;

    //////////////////////////////////////////////////
    // two register stages at the core boundary
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vld_s1     <= 1'b0;
            beat.valid <= 1'b0;
        end
        else
        begin
            vld_s1     <= i_tvld;
            beat.valid <= vld_s1;
        end
    end

    // beat contents only qualified by valid
    always_ff @(posedge clk)
    begin
        data_s1   <= i_tdata;
        keep_s1   <= i_tkeep;
        last_s1   <= i_tlast;
        user_s1   <= i_tuser;
        beat.data <= data_s1;
        beat.keep <= keep_s1;
        beat.last <= last_s1;
        beat.user <= user_s1;
    end

    // halt completions when tags run out, non-posted when tx is busy
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_pkt_halt <= '0;
        end
        else
        begin
            o_pkt_halt[axis_pkg::HALT_CPL] <= i_tag_full;
            o_pkt_halt[axis_pkg::HALT_NP]  <= ~i_cpld_tx_rdy;
        end
    end

endmodule

`default_nettype wire

//--- tlp_beat_if.sv
`default_nettype none

// one registered stream beat, counted whenever valid is high
interface tlp_beat_if;

    logic                        valid;
    logic [axis_pkg::DATA_W-1:0] data;
    logic [axis_pkg::KEEP_W-1:0] keep;
    logic                        last;
    logic [axis_pkg::USER_W-1:0] user;

    modport src
    (
        output valid, data, keep, last, user
    );

    modport snk
    (
        input valid, data, keep, last, user
    );

endinterface

`default_nettype wire

//--- tlp_pkg.sv
`default_nettype none

package tlp_pkg;

    // header field widths
    localparam int LEN_W   = 10;
    localparam int ADDR_W  = 64;
    localparam int TAG_W   = 8;
    localparam int ID_W    = 16;
    localparam int BCNT_W  = 12;
    localparam int LADDR_W = 7;
    localparam int TC_W    = 3;
    localparam int ATTR_W  = 3;
    localparam int BE_W    = 8;

    //////////////////////////////////////////////////
    // bit positions inside the header beat
    //////////////////////////////////////////////////
    localparam int FMT_TYPE_LO = 24;
    localparam int LEN_LO      = 0;
    localparam int TC_LO       = 20;
    localparam int ATTR_HI_BIT = 18;    // ido bit, top of attr
    localparam int ATTR_LO     = 12;    // relaxed ordering and no snoop
    localparam int REQ_ID_LO   = 48;
    localparam int TAG_LO      = 40;
    localparam int BE_LO       = 32;
    localparam int ADDR_DW2_LO = 64;
    localparam int ADDR_DW3_LO = 96;
    localparam int BCNT_LO     = 32;
    localparam int LADDR_LO    = 64;
    localparam int CPL_TAG_LO  = 72;

    // fmt and type of the first header dword
    typedef enum logic [7:0] {
        MRD_32   = 8'h00,
        MRDLK_32 = 8'h01,
        MRD_64   = 8'h20,
        MRDLK_64 = 8'h21,
        MWR_32   = 8'h40,
        MWR_64   = 8'h60,
        CPLD     = 8'h4A,
        CPLDLK   = 8'h4B
    } tlp_fmt_type_t;

    typedef enum logic [1:0] {
        CLS_NONE = 2'd0,
        CLS_MRD  = 2'd1,
        CLS_MWR  = 2'd2,
        CLS_CPLD = 2'd3
    } tlp_class_t;

endpackage

`default_nettype wire

//--- axis_pkg.sv
`default_nettype none

package axis_pkg;

    // stream beat
    localparam int DATA_W = 128;
    localparam int KEEP_W = 4;      // one keep bit per dword
    localparam int USER_W = 8;

    // user bit set on the final completion of a request
    localparam int USER_LAST_CPL = 3;

    //////////////////////////////////////////////////
    // halt vector back to the core
    //////////////////////////////////////////////////
    localparam int HALT_W   = 2;
    localparam int HALT_CPL = 0;
    localparam int HALT_NP  = 1;

endpackage

`default_nettype wire
